//--- logic/data_serializer.sv
// Frames matched data packets and shifts them out on miso
`timescale 1ns/1ps

module data_serializer (
    input  logic    clk,
    input  logic    rst,
    pit_resp_if.dst resp,
    output logic    miso
);

    ndn_ctrl_pkg::tx_state_e            state;
    logic [ndn_ctrl_pkg::CNT_W-1:0]     bit_cnt;
    logic [ndn_pkt_pkg::TX_SHIFT_W-1:0] tx_sr;

    // Busy for every cycle a frame bit sits on miso
    assign resp.busy = (state != ndn_ctrl_pkg::TX_IDLE);

    // Frame FSM, state names the bit on miso this cycle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= ndn_ctrl_pkg::TX_IDLE;
            bit_cnt <= '0;
            miso    <= 1'b1;
        end else begin
            case (state)
                ndn_ctrl_pkg::TX_IDLE: begin
                    if (resp.valid) begin
                        // Start bit
                        miso  <= 1'b0;
                        state <= ndn_ctrl_pkg::TX_START;
                    end else begin
                        miso <= 1'b1;
                    end
                end
                ndn_ctrl_pkg::TX_START: begin
                    miso    <= tx_sr[ndn_pkt_pkg::TX_SHIFT_W-1];
                    state   <= ndn_ctrl_pkg::TX_HEADER;
                    bit_cnt <= ndn_ctrl_pkg::CNT_W'(ndn_pkt_pkg::HDR_W - 1);
                end
                ndn_ctrl_pkg::TX_HEADER: begin
                    miso <= tx_sr[ndn_pkt_pkg::TX_SHIFT_W-1];
                    if (bit_cnt == '0) begin
                        state   <= ndn_ctrl_pkg::TX_PREFIX;
                        bit_cnt <= ndn_ctrl_pkg::CNT_W'(ndn_pkt_pkg::PREFIX_W - 1);
                    end else begin
                        bit_cnt <= bit_cnt - 1'b1;
                    end
                end
                ndn_ctrl_pkg::TX_PREFIX: begin
                    miso <= tx_sr[ndn_pkt_pkg::TX_SHIFT_W-1];
                    if (bit_cnt == '0) begin
                        state   <= ndn_ctrl_pkg::TX_DATA;
                        bit_cnt <= ndn_ctrl_pkg::CNT_W'(ndn_pkt_pkg::DATA_W - 1);
                    end else begin
                        bit_cnt <= bit_cnt - 1'b1;
                    end
                end
                ndn_ctrl_pkg::TX_DATA: begin
                    if (bit_cnt == '0) begin
                        // Low end bit after the last payload bit
                        miso  <= 1'b0;
                        state <= ndn_ctrl_pkg::TX_END;
                    end else begin
                        miso    <= tx_sr[ndn_pkt_pkg::TX_SHIFT_W-1];
                        bit_cnt <= bit_cnt - 1'b1;
                    end
                end
                ndn_ctrl_pkg::TX_END: begin
                    miso  <= 1'b1;
                    state <= ndn_ctrl_pkg::TX_IDLE;
                end
                default: begin
                    miso  <= 1'b1;
                    state <= ndn_ctrl_pkg::TX_IDLE;
                end
            endcase
        end
    end

    // Header, prefix and payload in one register, MSB leaves first
    always_ff @(posedge clk) begin
        if (state == ndn_ctrl_pkg::TX_IDLE) begin
            if (resp.valid) begin
                tx_sr <= {ndn_pkt_pkg::DATA_HDR, resp.prefix, resp.data};
            end
        end else begin
            tx_sr <= tx_sr << 1;
        end
    end

    // Line rests high between frames
    a_idle_line_high: assert property (
        @(posedge clk) disable iff (rst) (state == ndn_ctrl_pkg::TX_IDLE) |-> miso
    );

endmodule

//--- logic/interest_deserializer.sv
// Turns interest frames on mosi into one-cycle table insert requests
`timescale 1ns/1ps

module interest_deserializer (
    input  logic   clk,
    input  logic   rst,
    input  logic   mosi,
    pit_req_if.src req,
    output logic   frame_err
);

    ndn_ctrl_pkg::rx_state_e              state;
    logic [ndn_ctrl_pkg::CNT_W-1:0]       bit_cnt;
    logic [ndn_pkt_pkg::HDR_W-1:0]        hdr_sr;
    logic [ndn_pkt_pkg::PREFIX_W-1:0]     pfx_sr;
    logic                                 type_ok;

    // Header type bit must say interest
    assign type_ok = (hdr_sr[ndn_pkt_pkg::TYPE_BIT] == ndn_pkt_pkg::PKT_INTEREST);

    // Shift registers stay still outside their fields, so they feed req directly
    assign req.length = hdr_sr[ndn_pkt_pkg::LEN_W-1:0];
    assign req.prefix = pfx_sr;

    // The serial port only ever produces inserts
    assign req.op = ndn_ctrl_pkg::PIT_INSERT;

    // Frame FSM and bit counter
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= ndn_ctrl_pkg::RX_IDLE;
            bit_cnt   <= '0;
            req.valid <= 1'b0;
            frame_err <= 1'b0;
        end else begin
            // Both outputs are single-cycle pulses
            req.valid <= 1'b0;
            frame_err <= 1'b0;
            case (state)
                ndn_ctrl_pkg::RX_IDLE: begin
                    // Line idles high, a low bit opens a frame
                    if (!mosi) begin
                        state   <= ndn_ctrl_pkg::RX_HEADER;
                        bit_cnt <= ndn_ctrl_pkg::CNT_W'(ndn_pkt_pkg::HDR_W - 1);
                    end
                end
                ndn_ctrl_pkg::RX_HEADER: begin
                    if (bit_cnt == '0) begin
                        state   <= ndn_ctrl_pkg::RX_PREFIX;
                        bit_cnt <= ndn_ctrl_pkg::CNT_W'(ndn_pkt_pkg::PREFIX_W - 1);
                    end else begin
                        bit_cnt <= bit_cnt - 1'b1;
                    end
                end
                ndn_ctrl_pkg::RX_PREFIX: begin
                    if (bit_cnt == '0) begin
                        state <= ndn_ctrl_pkg::RX_END;
                    end else begin
                        bit_cnt <= bit_cnt - 1'b1;
                    end
                end
                ndn_ctrl_pkg::RX_END: begin
                    // End bit must be low and the packet an interest
                    if (!mosi && type_ok) begin
                        req.valid <= 1'b1;
                    end else begin
                        frame_err <= 1'b1;
                    end
                    state <= ndn_ctrl_pkg::RX_IDLE;
                end
                default: begin
                    state <= ndn_ctrl_pkg::RX_IDLE;
                end
            endcase
        end
    end

    // Field capture, MSB first
    always_ff @(posedge clk) begin
        if (state == ndn_ctrl_pkg::RX_HEADER) begin
            hdr_sr <= {hdr_sr[ndn_pkt_pkg::HDR_W-2:0], mosi};
        end
        if (state == ndn_ctrl_pkg::RX_PREFIX) begin
            pfx_sr <= {pfx_sr[ndn_pkt_pkg::PREFIX_W-2:0], mosi};
        end
    end

    // Frames are at least a full frame apart, so requests never run back to back
    a_req_single_cycle: assert property (
        @(posedge clk) disable iff (rst) req.valid |=> !req.valid
    );

endmodule

//--- logic/ndn_ctrl_pkg.sv
// Control encodings and table sizing for the deserializer, PIT and serializer
package ndn_ctrl_pkg;

    // Number of pending interest entries
    localparam int PIT_DEPTH = 4;
    localparam int PIT_IDX_W = $clog2(PIT_DEPTH);

    // Bit counter wide enough to walk the longest field
    localparam int CNT_W = $clog2(ndn_pkt_pkg::PREFIX_W);

    // Receive side, one state per frame field
    typedef enum logic [1:0] {
        RX_IDLE,
        RX_HEADER,
        RX_PREFIX,
        RX_END
    } rx_state_e;

    // Transmit side, state names the bit currently on miso
    typedef enum logic [2:0] {
        TX_IDLE,
        TX_START,
        TX_HEADER,
        TX_PREFIX,
        TX_DATA,
        TX_END
    } tx_state_e;

    // Operation applied to the table in a given cycle
    typedef enum logic {
        PIT_INSERT,
        PIT_MATCH
    } pit_op_e;

endpackage

//--- logic/ndn_mcu_link.sv
// Top of the MCU serial link, joins deserializer, PIT and serializer
`timescale 1ns/1ps

module ndn_mcu_link (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            mosi,
    output logic                            miso,
    input  logic                            net_valid,
    input  logic [ndn_pkt_pkg::PREFIX_W-1:0] net_prefix,
    input  logic [ndn_pkt_pkg::DATA_W-1:0]   net_data,
    output logic                            frame_err,
    output logic                            interest_drop,
    output logic                            data_drop
);

    // Interest path into the table
    pit_req_if req_if ();

    // Data path out of the table, busy flows back
    pit_resp_if resp_if ();

    // MCU interests in
    interest_deserializer u_rx (
        .clk       (clk),
        .rst       (rst),
        .mosi      (mosi),
        .req       (req_if.src),
        .frame_err (frame_err)
    );

    // Table and network-side matching
    pit_table u_pit (
        .clk           (clk),
        .rst           (rst),
        .req           (req_if.dst),
        .resp          (resp_if.src),
        .net_valid     (net_valid),
        .net_prefix    (net_prefix),
        .net_data      (net_data),
        .interest_drop (interest_drop),
        .data_drop     (data_drop)
    );

    // Data frames back to the MCU
    data_serializer u_tx (
        .clk  (clk),
        .rst  (rst),
        .resp (resp_if.dst),
        .miso (miso)
    );

endmodule

//--- logic/ndn_pkt_pkg.sv
// Packet format constants and packet type shared by the MCU serial link blocks
package ndn_pkt_pkg;

    // Name prefix and header field widths
    localparam int PREFIX_W = 64;
    localparam int LEN_W = 6;
    localparam int HDR_W = 8;

    // Position of the packet type bit inside the header byte
    localparam int TYPE_BIT = 6;

    // Data payload, kept small for this node
    localparam int DATA_BYTES = 8;
    localparam int DATA_W = DATA_BYTES * 8;

    // Start bit, header, prefix, end bit
    localparam int RX_FRAME_BITS = 1 + HDR_W + PREFIX_W + 1;

    // Start bit, header, prefix, payload, end bit
    localparam int TX_FRAME_BITS = 1 + HDR_W + PREFIX_W + DATA_W + 1;

    // Bits shifted out between start and end bit
    localparam int TX_SHIFT_W = HDR_W + PREFIX_W + DATA_W;

    // Header bit 6 of a frame
    typedef enum logic {
        PKT_DATA     = 1'b0,
        PKT_INTEREST = 1'b1
    } pkt_type_e;

    // Outgoing data header: filler bit, type 0, length field unused
    localparam logic [HDR_W-1:0] DATA_HDR = {1'b0, PKT_DATA, {LEN_W{1'b0}}};

endpackage

//--- logic/pit_req_if.sv
// Decoded interest handed from the serial deserializer to the pending interest table
`timescale 1ns/1ps

interface pit_req_if;

    // One-cycle strobe, the fields below only count while it is high
    logic                           valid;
    logic [ndn_pkt_pkg::LEN_W-1:0]    length;
    logic [ndn_pkt_pkg::PREFIX_W-1:0] prefix;
    ndn_ctrl_pkg::pit_op_e          op;

    // Deserializer side
    modport src (
        output valid,
        output length,
        output prefix,
        output op
    );

    // Table side
    modport dst (
        input valid,
        input length,
        input prefix,
        input op
    );

endinterface

//--- logic/pit_resp_if.sv
// Matched data packet handed from the pending interest table to the serializer
`timescale 1ns/1ps

interface pit_resp_if;

    // One-cycle strobe with the packet to send
    logic                           valid;
    logic [ndn_pkt_pkg::PREFIX_W-1:0] prefix;
    logic [ndn_pkt_pkg::DATA_W-1:0]   data;

    // High while a frame is on miso, no strobe allowed then
    logic                           busy;

    // Table side
    modport src (
        output valid,
        output prefix,
        output data,
        input  busy
    );

    // Serializer side
    modport dst (
        input  valid,
        input  prefix,
        input  data,
        output busy
    );

endinterface

//--- logic/pit_table.sv
// Pending interest table that stores interests and matches network data against them
`timescale 1ns/1ps

module pit_table (
    input  logic                            clk,
    input  logic                            rst,
    pit_req_if.dst                          req,
    pit_resp_if.src                         resp,
    input  logic                            net_valid,
    input  logic [ndn_pkt_pkg::PREFIX_W-1:0] net_prefix,
    input  logic [ndn_pkt_pkg::DATA_W-1:0]   net_data,
    output logic                            interest_drop,
    output logic                            data_drop
);

    // Entry storage
    logic [ndn_ctrl_pkg::PIT_DEPTH-1:0] ent_valid;
    logic [ndn_pkt_pkg::LEN_W-1:0]      ent_len [ndn_ctrl_pkg::PIT_DEPTH];
    logic [ndn_pkt_pkg::PREFIX_W-1:0]   ent_pfx [ndn_ctrl_pkg::PIT_DEPTH];

    // Data strobe parked for one cycle behind an insert
    logic                             pend_valid;
    logic [ndn_pkt_pkg::PREFIX_W-1:0] pend_prefix;
    logic [ndn_pkt_pkg::DATA_W-1:0]   pend_data;

    // Strobe being looked up this cycle
    ndn_ctrl_pkg::pit_op_e            cur_op;
    logic                             cur_valid;
    logic [ndn_pkt_pkg::PREFIX_W-1:0] cur_prefix;
    logic [ndn_pkt_pkg::DATA_W-1:0]   cur_data;
    logic                             do_insert;
    logic                             do_match;
    logic                             blocked;

    // Lookup results
    logic [ndn_ctrl_pkg::PIT_DEPTH-1:0] hit;
    logic                               hit_any;
    logic                               free_any;
    logic [ndn_ctrl_pkg::PIT_IDX_W-1:0] hit_idx;
    logic [ndn_ctrl_pkg::PIT_IDX_W-1:0] free_idx;

    // Top len bits set, zero length compares the whole prefix
    function automatic logic [ndn_pkt_pkg::PREFIX_W-1:0] len_mask(
        input logic [ndn_pkt_pkg::LEN_W-1:0] len
    );
        if (len == '0) begin
            len_mask = '1;
        end else begin
            len_mask = ~({ndn_pkt_pkg::PREFIX_W{1'b1}} >> len);
        end
    endfunction

    // An insert owns the cycle, a data strobe waits behind it
    assign cur_op    = req.valid ? req.op : ndn_ctrl_pkg::PIT_MATCH;
    assign do_insert = req.valid && (cur_op == ndn_ctrl_pkg::PIT_INSERT);

    // Parked strobe goes first
    assign cur_valid  = pend_valid || net_valid;
    assign cur_prefix = pend_valid ? pend_prefix : net_prefix;
    assign cur_data   = pend_valid ? pend_data : net_data;
    assign do_match   = cur_valid && (cur_op == ndn_ctrl_pkg::PIT_MATCH);

    // Serializer busy lags resp.valid by one cycle, so cover that cycle too
    assign blocked = resp.busy || resp.valid;

    // Parallel compare and lowest-index pick, low index overwrites
    always_comb begin
        hit_idx  = '0;
        hit_any  = 1'b0;
        free_idx = '0;
        free_any = 1'b0;
        for (int i = ndn_ctrl_pkg::PIT_DEPTH - 1; i >= 0; i--) begin
            hit[i] = ent_valid[i] &&
                     (((cur_prefix ^ ent_pfx[i]) & len_mask(ent_len[i])) == '0);
            if (hit[i]) begin
                hit_idx = ndn_ctrl_pkg::PIT_IDX_W'(i);
                hit_any = 1'b1;
            end
            if (!ent_valid[i]) begin
                free_idx = ndn_ctrl_pkg::PIT_IDX_W'(i);
                free_any = 1'b1;
            end
        end
    end

    // Valid bits, response strobe and drop pulses
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ent_valid     <= '0;
            pend_valid    <= 1'b0;
            resp.valid    <= 1'b0;
            interest_drop <= 1'b0;
            data_drop     <= 1'b0;
        end else begin
            resp.valid    <= 1'b0;
            interest_drop <= 1'b0;
            data_drop     <= 1'b0;
            pend_valid    <= net_valid && do_insert;
            if (do_insert) begin
                if (free_any) begin
                    ent_valid[free_idx] <= 1'b1;
                end else begin
                    interest_drop <= 1'b1;
                end
            end
            if (do_match) begin
                if (blocked || !hit_any) begin
                    data_drop <= 1'b1;
                end else begin
                    ent_valid[hit_idx] <= 1'b0;
                    resp.valid         <= 1'b1;
                end
            end
            // A fresh strobe landing on a parked one is lost
            if (pend_valid && net_valid) begin
                data_drop <= 1'b1;
            end
        end
    end

    // Payload side
    always_ff @(posedge clk) begin
        if (do_insert && free_any) begin
            ent_len[free_idx] <= req.length;
            ent_pfx[free_idx] <= req.prefix;
        end
        if (net_valid && do_insert) begin
            pend_prefix <= net_prefix;
            pend_data   <= net_data;
        end
        if (do_match && !blocked && hit_any) begin
            resp.prefix <= cur_prefix;
            resp.data   <= cur_data;
        end
    end

    // Serializer never sees a new packet mid-frame
    a_no_resp_while_busy: assert property (
        @(posedge clk) disable iff (rst) resp.valid |-> !resp.busy
    );

    // Interest drop only when an insert found every slot taken
    a_drop_means_full: assert property (
        @(posedge clk) disable iff (rst)
        interest_drop |-> $past(req.valid && (&ent_valid))
    );

endmodule

//--- ndn_mcu_link.f
logic/ndn_pkt_pkg.sv
logic/ndn_ctrl_pkg.sv
logic/pit_req_if.sv
logic/pit_resp_if.sv
logic/interest_deserializer.sv
logic/pit_table.sv
logic/data_serializer.sv
logic/ndn_mcu_link.sv
verif/mcu_model.sv
verif/ndn_mcu_link_tb.sv

//--- verif/mcu_model.sv
// Testbench MCU model, shifts interest frames onto mosi and captures data frames from miso
`timescale 1ns/1ps

module mcu_model (
    input  logic                             clk,
    input  logic                             miso,
    output logic                             mosi,
    output logic [ndn_pkt_pkg::HDR_W-1:0]    rx_hdr,
    output logic [ndn_pkt_pkg::PREFIX_W-1:0] rx_prefix,
    output logic [ndn_pkt_pkg::DATA_W-1:0]   rx_data,
    output logic                             rx_end,
    output int                               start_cnt,
    output int                               frame_cnt
);

    // Bits between start and end bit of a data frame
    localparam int CAP_W = ndn_pkt_pkg::HDR_W + ndn_pkt_pkg::PREFIX_W + ndn_pkt_pkg::DATA_W;

    // Full interest frame, start bit to end bit
    localparam int RX_W = ndn_pkt_pkg::RX_FRAME_BITS;

    logic [CAP_W-1:0] cap_sr;

    // Send one interest frame, MSB first, one bit per clock
    task automatic send_frame(
        input logic [ndn_pkt_pkg::HDR_W-1:0]    hdr,
        input logic [ndn_pkt_pkg::PREFIX_W-1:0] prefix,
        input logic                             end_bit
    );
        logic [RX_W-1:0] bits;
        int              i;
        bits = {1'b0, hdr, prefix, end_bit};
        for (i = RX_W - 1; i >= 0; i--) begin
            @(posedge clk);
            mosi <= bits[i];
        end
        // Line back to idle
        @(posedge clk);
        mosi <= 1'b1;
    endtask

    // miso watcher, sampled at the falling edge where the line is settled
    initial begin
        mosi      = 1'b1;
        start_cnt = 0;
        frame_cnt = 0;
        forever begin
            @(negedge clk);
            // A low bit on an idle line opens a frame
            if (miso === 1'b0) begin
                start_cnt = start_cnt + 1;
                repeat (CAP_W) begin
                    @(negedge clk);
                    cap_sr = {cap_sr[CAP_W-2:0], miso};
                end
                @(negedge clk);
                rx_end    = miso;
                // Split into header, prefix, payload
                rx_hdr    = cap_sr[CAP_W-1 -: ndn_pkt_pkg::HDR_W];
                rx_prefix = cap_sr[ndn_pkt_pkg::DATA_W +: ndn_pkt_pkg::PREFIX_W];
                rx_data   = cap_sr[ndn_pkt_pkg::DATA_W-1:0];
                frame_cnt = frame_cnt + 1;
            end
        end
    end

endmodule

//--- verif/ndn_mcu_link_tb.sv
// Table-driven testbench for the MCU link, runs interest and data scenarios through the PIT
`timescale 1ns/1ps

module ndn_mcu_link_tb;

    localparam int CLK_PERIOD = 100;
    localparam int NUM_ROWS   = 25;
    localparam int PW         = ndn_pkt_pkg::PREFIX_W;
    localparam int DW         = ndn_pkt_pkg::DATA_W;
    localparam int LW         = ndn_pkt_pkg::LEN_W;

    // Row actions
    localparam int ACT_INTEREST = 0;
    localparam int ACT_BAD_END  = 1;
    localparam int ACT_BAD_TYPE = 2;
    localparam int ACT_DATA     = 3;

    // Row outcomes, also used as event counter selectors
    localparam int EXP_NONE      = 0;
    localparam int EXP_FRAME     = 1;
    localparam int EXP_FRAME_ERR = 2;
    localparam int EXP_INT_DROP  = 3;
    localparam int EXP_DATA_DROP = 4;
    localparam int EV_DONE       = 5;

    logic          clk;
    logic          rst;
    logic          mosi;
    logic          miso;
    logic          net_valid;
    logic [PW-1:0] net_prefix;
    logic [DW-1:0] net_data;
    logic          frame_err;
    logic          interest_drop;
    logic          data_drop;

    // Captured data frame
    logic [7:0]    rx_hdr;
    logic [PW-1:0] rx_prefix;
    logic [DW-1:0] rx_data;
    logic          rx_end;
    int            start_cnt;
    int            frame_cnt;

    // Pulse counters
    int err_cnt   = 0;
    int idrop_cnt = 0;
    int ddrop_cnt = 0;

    int          errors;
    int          n_rows;
    int          row;
    logic [31:0] lcg_state;

    // Stimulus table
    int            act_tab [NUM_ROWS];
    logic [LW-1:0] len_tab [NUM_ROWS];
    logic [PW-1:0] pfx_tab [NUM_ROWS];
    logic [DW-1:0] dat_tab [NUM_ROWS];
    int            exp_tab [NUM_ROWS];
    logic          ovl_tab [NUM_ROWS];
    logic [PW-1:0] pool    [11];

    // Frame started on miso but not yet checked
    logic          pend_frame;
    logic [PW-1:0] pend_prefix;
    logic [DW-1:0] pend_data;

    ndn_mcu_link DUT (
        .clk           (clk),
        .rst           (rst),
        .mosi          (mosi),
        .miso          (miso),
        .net_valid     (net_valid),
        .net_prefix    (net_prefix),
        .net_data      (net_data),
        .frame_err     (frame_err),
        .interest_drop (interest_drop),
        .data_drop     (data_drop)
    );

    mcu_model mcu (
        .clk       (clk),
        .miso      (miso),
        .mosi      (mosi),
        .rx_hdr    (rx_hdr),
        .rx_prefix (rx_prefix),
        .rx_data   (rx_data),
        .rx_end    (rx_end),
        .start_cnt (start_cnt),
        .frame_cnt (frame_cnt)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Count single-cycle pulses at the falling edge
    always @(negedge clk) begin
        if (!rst) begin
            if (frame_err) begin
                err_cnt = err_cnt + 1;
            end
            if (interest_drop) begin
                idrop_cnt = idrop_cnt + 1;
            end
            if (data_drop) begin
                ddrop_cnt = ddrop_cnt + 1;
            end
        end
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic logic [63:0] random_word();
        logic [31:0] hi;
        hi = lcg_next();
        return {hi, lcg_next()};
    endfunction

    task automatic abort_run();
        $display("Test failures found");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] got);
        if (got !== exp) begin
            $display("FAIL %s exp=%h got=%h", name, exp, got);
            errors = errors + 1;
            abort_run();
        end
    endtask

    function automatic int event_count(input int kind);
        case (kind)
            EXP_FRAME:     return start_cnt;
            EXP_FRAME_ERR: return err_cnt;
            EXP_INT_DROP:  return idrop_cnt;
            EXP_DATA_DROP: return ddrop_cnt;
            EV_DONE:       return frame_cnt;
            default:       return 0;
        endcase
    endfunction

    // Counters change at negedge, so polling at posedge reads settled values
    task automatic wait_event(input int kind, input int target, input int limit, input string what);
        int n;
        n = 0;
        while (event_count(kind) < target) begin
            if (n >= limit) begin
                $display("Timed out after %0d cycles waiting for %s in row %0d", n, what, row);
                abort_run();
            end
            @(posedge clk);
            n = n + 1;
        end
    endtask

    task automatic add_row(input int act, input logic [LW-1:0] len, input logic [PW-1:0] pfx,
                           input logic [DW-1:0] dat, input int exp, input logic ovl);
        act_tab[n_rows] = act;
        len_tab[n_rows] = len;
        pfx_tab[n_rows] = pfx;
        dat_tab[n_rows] = dat;
        exp_tab[n_rows] = exp;
        ovl_tab[n_rows] = ovl;
        n_rows = n_rows + 1;
    endtask

    task automatic build_table();
        int k;
        for (k = 0; k < 11; k++) begin
            pool[k] = random_word();
        end
        // Exact match answered once, repeat strobe dropped
        add_row(ACT_INTEREST, 6'd0, pool[0], '0, EXP_NONE, 1'b0);
        add_row(ACT_DATA, 6'd0, pool[0], random_word(), EXP_FRAME, 1'b0);
        add_row(ACT_DATA, 6'd0, pool[0], random_word(), EXP_DATA_DROP, 1'b0);
        // 16-bit prefix, bit 48 is inside the compared field
        add_row(ACT_INTEREST, 6'd16, pool[1], '0, EXP_NONE, 1'b0);
        add_row(ACT_DATA, 6'd0, pool[1] ^ 64'h0001_0000_0000_0000, random_word(),
                EXP_DATA_DROP, 1'b0);
        add_row(ACT_DATA, 6'd0, pool[1] ^ 64'h0000_ffff_ffff_ffff, random_word(), EXP_FRAME, 1'b0);
        // Malformed interests never reach the table
        add_row(ACT_BAD_END, 6'd0, pool[2], '0, EXP_FRAME_ERR, 1'b0);
        add_row(ACT_BAD_TYPE, 6'd0, pool[3], '0, EXP_FRAME_ERR, 1'b0);
        add_row(ACT_DATA, 6'd0, pool[2], random_word(), EXP_DATA_DROP, 1'b0);
        add_row(ACT_DATA, 6'd0, pool[3], random_word(), EXP_DATA_DROP, 1'b0);
        // Fill the table, fifth interest overflows
        for (k = 4; k < 8; k++) begin
            add_row(ACT_INTEREST, 6'd0, pool[k], '0, EXP_NONE, 1'b0);
        end
        add_row(ACT_INTEREST, 6'd0, pool[8], '0, EXP_INT_DROP, 1'b0);
        for (k = 4; k < 8; k++) begin
            add_row(ACT_DATA, 6'd0, pool[k], random_word(), EXP_FRAME, 1'b0);
        end
        // Strobe during a frame is dropped, frame in flight checked afterwards
        add_row(ACT_INTEREST, 6'd0, pool[9], '0, EXP_NONE, 1'b0);
        add_row(ACT_INTEREST, 6'd0, pool[10], '0, EXP_NONE, 1'b0);
        add_row(ACT_DATA, 6'd0, pool[9], random_word(), EXP_FRAME, 1'b1);
        add_row(ACT_DATA, 6'd0, pool[10], random_word(), EXP_DATA_DROP, 1'b0);
        add_row(ACT_DATA, 6'd0, pool[10], random_word(), EXP_FRAME, 1'b0);
        // Overflowed interest was never stored
        add_row(ACT_DATA, 6'd0, pool[8], random_word(), EXP_DATA_DROP, 1'b0);
    endtask

    // One-cycle network strobe
    task automatic strobe_data(input logic [PW-1:0] pfx, input logic [DW-1:0] dat);
        @(posedge clk);
        net_valid  <= 1'b1;
        net_prefix <= pfx;
        net_data   <= dat;
        @(posedge clk);
        net_valid <= 1'b0;
    endtask

    task automatic apply_row(input int i);
        int err0;
        int idrop0;
        int ddrop0;
        int start0;
        err0   = err_cnt;
        idrop0 = idrop_cnt;
        ddrop0 = ddrop_cnt;
        start0 = start_cnt;
        // Header bit 7 set on purpose, the link ignores it
        case (act_tab[i])
            ACT_INTEREST: mcu.send_frame({2'b11, len_tab[i]}, pfx_tab[i], 1'b0);
            ACT_BAD_END:  mcu.send_frame({2'b11, len_tab[i]}, pfx_tab[i], 1'b1);
            ACT_BAD_TYPE: mcu.send_frame({2'b10, len_tab[i]}, pfx_tab[i], 1'b0);
            default:      strobe_data(pfx_tab[i], dat_tab[i]);
        endcase
        if (exp_tab[i] != EXP_NONE) begin
            wait_event(exp_tab[i], event_count(exp_tab[i]) + 1, 10, "row outcome");
        end
        if (exp_tab[i] == EXP_FRAME) begin
            pend_frame  = 1'b1;
            pend_prefix = pfx_tab[i];
            pend_data   = dat_tab[i];
        end
        // Settle, then no stray pulse or frame start
        repeat (3) @(posedge clk);
        check_value("frame_err pulses", err0 + (exp_tab[i] == EXP_FRAME_ERR), err_cnt);
        check_value("interest_drop pulses", idrop0 + (exp_tab[i] == EXP_INT_DROP), idrop_cnt);
        check_value("data_drop pulses", ddrop0 + (exp_tab[i] == EXP_DATA_DROP), ddrop_cnt);
        check_value("miso frame starts", start0 + (exp_tab[i] == EXP_FRAME), start_cnt);
        if (pend_frame && !ovl_tab[i]) begin
            wait_event(EV_DONE, start_cnt, ndn_pkt_pkg::TX_FRAME_BITS + 10, "end of data frame");
            // Data header is all zero, type 0
            check_value("miso header", 8'h00, rx_hdr);
            check_value("miso prefix", pend_prefix, rx_prefix);
            check_value("miso data", pend_data, rx_data);
            check_value("miso end bit", 1'b0, rx_end);
            pend_frame = 1'b0;
        end
    endtask

    // Watchdog sized from the row count
    initial begin
        #(NUM_ROWS * (ndn_pkt_pkg::RX_FRAME_BITS + ndn_pkt_pkg::TX_FRAME_BITS + 20) * CLK_PERIOD);
        $display("Timeout: simulation ran past the limit for %0d rows", NUM_ROWS);
        abort_run();
    end

    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        net_valid  = 1'b0;
        net_prefix = '0;
        net_data   = '0;
        errors     = 0;
        n_rows     = 0;
        pend_frame = 1'b0;
        lcg_state  = 32'd36;
        build_table();
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        for (row = 0; row < n_rows; row++) begin
            apply_row(row);
        end
        if (errors == 0) begin
            $display("All tests passed!");
            $finish;
        end else begin
            abort_run();
        end
    end

endmodule
